// ==== tests/uc_patterns.hex ====
// test(behavior digit, step digit) port op(0 read, 1 write) addr wdata expected check
// check: 0 none, 1 read data, 2 {software_irq, timer_irq, freeze} after the response
11 0 0 00000 00000000 00000001 2
11 0 0 00004 00000000 00000000 1
11 1 0 00004 00000000 00000000 1
11 1 0 00000 00000000 00000001 1
21 0 1 80000 11110000 00000000 1
21 0 1 80004 22220001 00000000 1
21 0 1 80008 33330002 00000000 1
21 0 1 8000c 44440003 00000000 1
21 0 1 80010 55550004 00000000 1
21 0 1 80214 66660005 00000000 1
22 1 0 80000 00000000 11110000 1
22 1 0 80004 00000000 22220001 1
22 1 0 80008 00000000 33330002 1
22 1 0 8000c 00000000 44440003 1
22 1 0 80210 00000000 55550004 1
22 1 0 80014 00000000 66660005 1
31 0 1 00004 1234abcd 00000000 1
31 0 0 00004 00000000 1234abcd 1
31 0 1 00000 00000000 00000000 2
31 0 1 05004 deadbeef 00000000 1
31 0 0 05004 00000000 00000000 1
31 0 0 00004 00000000 1234abcd 1
31 1 0 00100 00000000 00000000 1
31 1 1 00100 ffffffff 00000000 1
31 1 0 00100 00000000 00000000 1
41 0 1 01000 00000001 00000004 2
41 0 1 01008 00000000 00000006 2
41 0 1 01008 ffffffff 00000004 2
41 0 1 01010 00000000 00000004 2
41 0 0 01008 00000000 ffffffff 1
41 0 1 01000 00000000 00000000 2
51 0 1 80040 a0a0a0a0 00000000 1
51 0 0 80040 00000000 a0a0a0a0 1
51 0 1 80048 a1a1a1a1 00000000 1
51 0 0 80048 00000000 a1a1a1a1 1
51 0 0 80000 00000000 11110000 1
51 1 1 80050 b0b0b0b0 00000000 1
51 1 0 80050 00000000 b0b0b0b0 1
51 1 1 80058 b1b1b1b1 00000000 1
51 1 0 80058 00000000 b1b1b1b1 1
51 1 0 80008 00000000 33330002 1

// ==== filelist.f ====
common/uc_msg_pkg.sv
common/uc_map_pkg.sv
xbar/uc_rr_arb.sv
xbar/uc_fwd_xbar.sv
xbar/uc_rev_xbar.sv
devices/uc_cfg_regs.sv
devices/uc_clint.sv
devices/uc_mem_bank.sv
rtl/uc_top.sv
tests/uc_props.sv
tests/uc_tb.sv

// ==== Makefile ====
# Verilator build and run of the interconnect testbench
VERILATOR ?= verilator
TOP ?= uc_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/uc_tb.sv ====
// Testbench for the interconnect; replays the pattern file on both ports and checks responses
`timescale 1ns/1ns

module uc_tb;

  localparam int NUM_BANKS = 2;
  localparam int BANK_WORDS = 64;
  localparam int COLS = 7;
  localparam int MAX_LINES = 64;
  localparam int RESET_CYCLES = 5;
  localparam int CYCLES_PER_LINE = 50;

  logic                                                       clk_i;
  logic                                                       rst_n_i;
  logic [uc_msg_pkg::NUM_SRC-1:0]                             req_v_i;
  logic [uc_msg_pkg::NUM_SRC-1:0]                             req_ready_o;
  uc_msg_pkg::opcode_e [uc_msg_pkg::NUM_SRC-1:0]              req_op_i;
  logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::ADDR_W-1:0]     req_addr_i;
  logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::DATA_W-1:0]     req_wdata_i;
  logic [uc_msg_pkg::NUM_SRC-1:0]                             rsp_v_o;
  logic [uc_msg_pkg::NUM_SRC-1:0]                             rsp_ready_i;
  logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::DATA_W-1:0]     rsp_rdata_o;
  logic                                                       freeze_o;
  logic                                                       timer_irq_o;
  logic                                                       software_irq_o;

  logic [31:0] pat [COLS*MAX_LINES];
  logic [31:0] rnd;
  integer      seed;
  int          n_lines;
  int          cycles = 0;
  int          limit = CYCLES_PER_LINE * MAX_LINES;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;

  uc_top #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) uut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_v_i       (req_v_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .rsp_v_o       (rsp_v_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_rdata_o   (rsp_rdata_o),
    .freeze_o      (freeze_o),
    .timer_irq_o   (timer_irq_o),
    .software_irq_o(software_irq_o)
  );

  always #5 clk_i = ~clk_i;

  // Each port ready about three cycles in four
  always @(posedge clk_i)
  begin
    #1;
    rnd = $random(seed);
    rsp_ready_i[0] = rnd[0] | rnd[1];
    rsp_ready_i[1] = rnd[2] | rnd[3];
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout: run still busy after %0d cycles", limit);
      $display("Something failed");
      $finish;
    end
  end

  function automatic string test_title(input int b);
    case (b)
      1: return "reset state";
      2: return "memory banks";
      3: return "configuration slice";
      4: return "interruptor";
      5: return "contention and back-pressure";
      default: return "unknown";
    endcase
  endfunction

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  // One transaction of pattern line k on its own port
  task automatic run_line(input int k);
    uc_msg_pkg::src_id_t p;
    logic [31:0]         want;
    logic [31:0]         flag;
    logic [31:0]         got;
    logic [2:0]          side;
    p = uc_msg_pkg::src_id_t'(pat[COLS*k+1]);
    want = pat[COLS*k+5];
    flag = pat[COLS*k+6];
    req_op_i[p] = pat[COLS*k+2][0] ? uc_msg_pkg::OP_WRITE : uc_msg_pkg::OP_READ;
    req_addr_i[p] = pat[COLS*k+3][uc_msg_pkg::ADDR_W-1:0];
    req_wdata_i[p] = pat[COLS*k+4];
    req_v_i[p] = 1'b1;
    @(negedge clk_i);
    checks++;
    assert (!rsp_v_o[p])
    else
    begin
      $display("port %0d shows a response with no request outstanding at %0t", p, $time);
      count_error();
    end
    while (!req_ready_o[p])
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_v_i[p] = 1'b0;
    @(negedge clk_i);
    while (!(rsp_v_o[p] && rsp_ready_i[p]))
      @(negedge clk_i);
    got = rsp_rdata_o[p];
    @(posedge clk_i);
    #1;
    side = {software_irq_o, timer_irq_o, freeze_o};
    if (flag == 1)
    begin
      checks++;
      assert (got == want)
      else
      begin
        $display("mismatch at %0t: port %0d addr %05h read %08h, expected %08h",
                 $time, p, pat[COLS*k+3], got, want);
        count_error();
      end
    end
    else if (flag == 2)
    begin
      checks++;
      assert (side == want[2:0])
      else
      begin
        $display("mismatch at %0t: port %0d addr %05h sw/timer/freeze %03b, expected %03b",
                 $time, p, pat[COLS*k+3], side, want[2:0]);
        count_error();
      end
    end
  endtask

  task automatic run_port(input uc_msg_pkg::src_id_t p, input int first, input int last);
    for (int k = first; k < last; k++)
    begin
      if (uc_msg_pkg::src_id_t'(pat[COLS*k+1]) == p)
        run_line(k);
    end
  endtask

  task automatic report_test(input int b);
    if (test_errors == 0)
      $display("test %0d %s: passed", b, test_title(b));
    else
      $display("test %0d %s: %0d errors", b, test_title(b), test_errors);
  endtask

  initial
  begin
    int i;
    int j;
    seed = 81;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    // Both ports already request during reset and must not be accepted
    req_v_i = '1;
    for (int p = 0; p < uc_msg_pkg::NUM_SRC; p++)
      req_op_i[p] = uc_msg_pkg::OP_READ;
    req_addr_i = '0;
    req_wdata_i = '0;
    rsp_ready_i = '0;
    for (int k = 0; k < COLS * MAX_LINES; k++)
      pat[k] = '0;
    $readmemh("tests/uc_patterns.hex", pat);
    n_lines = 0;
    while (n_lines < MAX_LINES && pat[COLS*n_lines] != 0)
      n_lines++;
    limit = CYCLES_PER_LINE * n_lines + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    req_v_i = '0;
    // Lines of one step run on both ports at once, steps run in order
    i = 0;
    while (i < n_lines)
    begin
      j = i;
      while (j < n_lines && pat[COLS*j] == pat[COLS*i])
        j++;
      fork
        run_port(1'b0, i, j);
        run_port(1'b1, i, j);
      join
      if (j == n_lines || pat[COLS*j][7:4] != pat[COLS*i][7:4])
      begin
        report_test(int'(pat[COLS*i][7:4]));
        test_errors = 0;
      end
      i = j;
    end
    $display("%0d checks, %0d errors, %0d bound assertion failures",
             checks, errors, uut.u_props.fail_count);
    if (errors == 0 && uut.u_props.fail_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== tests/uc_props.sv ====
// Handshake and reset properties of the interconnect ports, bound to the top level
`timescale 1ns/1ns

module uc_props (
  input logic                                                   clk_i,
  input logic                                                   rst_n_i,
  input logic [uc_msg_pkg::NUM_SRC-1:0]                         req_ready_o,
  input logic [uc_msg_pkg::NUM_SRC-1:0]                         rsp_v_o,
  input logic [uc_msg_pkg::NUM_SRC-1:0]                         rsp_ready_i,
  input logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::DATA_W-1:0] rsp_rdata_o
);

  int fail_count = 0;

  for (genvar p = 0; p < uc_msg_pkg::NUM_SRC; p++)
  begin : g_port
    // A stalled response keeps its valid and data
    rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_v_o[p] && !rsp_ready_i[p] |=> rsp_v_o[p] && $stable(rsp_rdata_o[p]))
    else
    begin
      $error("response on port %0d dropped or changed before its transfer", p);
      fail_count++;
    end
  end

  ready_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> req_ready_o == '0)
  else
  begin
    $error("request ready raised while in reset");
    fail_count++;
  end

  // Sync reset clears the response registers one edge later
  rsp_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> rsp_v_o == '0)
  else
  begin
    $error("response valid raised while in reset");
    fail_count++;
  end

endmodule

bind uc_top uc_props u_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_ready_o(req_ready_o),
  .rsp_v_o    (rsp_v_o),
  .rsp_ready_i(rsp_ready_i),
  .rsp_rdata_o(rsp_rdata_o)
);

// ==== rtl/uc_top.sv ====
// Interconnect top; connects the core and host ports to config, clint and RAM banks
`timescale 1ns/1ns

module uc_top #(
  parameter int NUM_BANKS = 2,
  parameter int BANK_WORDS = 64
) (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  input  logic [uc_msg_pkg::NUM_SRC-1:0]                             req_v_i,
  output logic [uc_msg_pkg::NUM_SRC-1:0]                             req_ready_o,
  input  uc_msg_pkg::opcode_e [uc_msg_pkg::NUM_SRC-1:0]              req_op_i,
  input  logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::ADDR_W-1:0]     req_addr_i,
  input  logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::DATA_W-1:0]     req_wdata_i,
  output logic [uc_msg_pkg::NUM_SRC-1:0]                             rsp_v_o,
  input  logic [uc_msg_pkg::NUM_SRC-1:0]                             rsp_ready_i,
  output logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::DATA_W-1:0]     rsp_rdata_o,
  output logic                                                       freeze_o,
  output logic                                                       timer_irq_o,
  output logic                                                       software_irq_o
);

  localparam int NUM_DEV = uc_map_pkg::BANK_ID0 + NUM_BANKS;

  logic [NUM_DEV-1:0]                            dev_req_v;
  logic [NUM_DEV-1:0]                            dev_req_ready;
  uc_msg_pkg::opcode_e [NUM_DEV-1:0]             dev_req_op;
  logic [NUM_DEV-1:0][uc_msg_pkg::ADDR_W-1:0]    dev_req_addr;
  logic [NUM_DEV-1:0][uc_msg_pkg::DATA_W-1:0]    dev_req_wdata;
  uc_msg_pkg::src_id_t [NUM_DEV-1:0]             dev_req_src;
  logic [NUM_DEV-1:0]                            dev_rsp_v;
  logic [NUM_DEV-1:0]                            dev_rsp_ready;
  logic [NUM_DEV-1:0][uc_msg_pkg::DATA_W-1:0]    dev_rsp_rdata;
  uc_msg_pkg::src_id_t [NUM_DEV-1:0]             dev_rsp_src;
  logic [uc_msg_pkg::NUM_SRC-1:0]                rsp_done;

  uc_fwd_xbar #(.NUM_BANKS(NUM_BANKS)) u_fwd_xbar (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_v_i        (req_v_i),
    .req_ready_o    (req_ready_o),
    .req_op_i       (req_op_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .dev_req_v_o    (dev_req_v),
    .dev_req_ready_i(dev_req_ready),
    .dev_req_op_o   (dev_req_op),
    .dev_req_addr_o (dev_req_addr),
    .dev_req_wdata_o(dev_req_wdata),
    .dev_req_src_o  (dev_req_src),
    .rsp_done_i     (rsp_done)
  );

  uc_rev_xbar #(.NUM_BANKS(NUM_BANKS)) u_rev_xbar (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dev_rsp_v_i    (dev_rsp_v),
    .dev_rsp_ready_o(dev_rsp_ready),
    .dev_rsp_rdata_i(dev_rsp_rdata),
    .dev_rsp_src_i  (dev_rsp_src),
    .rsp_v_o        (rsp_v_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_rdata_o    (rsp_rdata_o),
    .rsp_done_o     (rsp_done)
  );

  uc_cfg_regs u_cfg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_v_i    (dev_req_v[uc_map_pkg::CFG_ID]),
    .req_ready_o(dev_req_ready[uc_map_pkg::CFG_ID]),
    .req_op_i   (dev_req_op[uc_map_pkg::CFG_ID]),
    .req_addr_i (dev_req_addr[uc_map_pkg::CFG_ID]),
    .req_wdata_i(dev_req_wdata[uc_map_pkg::CFG_ID]),
    .req_src_i  (dev_req_src[uc_map_pkg::CFG_ID]),
    .rsp_v_o    (dev_rsp_v[uc_map_pkg::CFG_ID]),
    .rsp_ready_i(dev_rsp_ready[uc_map_pkg::CFG_ID]),
    .rsp_rdata_o(dev_rsp_rdata[uc_map_pkg::CFG_ID]),
    .rsp_src_o  (dev_rsp_src[uc_map_pkg::CFG_ID]),
    .freeze_o   (freeze_o)
  );

  uc_clint u_clint (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_v_i       (dev_req_v[uc_map_pkg::CLINT_ID]),
    .req_ready_o   (dev_req_ready[uc_map_pkg::CLINT_ID]),
    .req_op_i      (dev_req_op[uc_map_pkg::CLINT_ID]),
    .req_addr_i    (dev_req_addr[uc_map_pkg::CLINT_ID]),
    .req_wdata_i   (dev_req_wdata[uc_map_pkg::CLINT_ID]),
    .req_src_i     (dev_req_src[uc_map_pkg::CLINT_ID]),
    .rsp_v_o       (dev_rsp_v[uc_map_pkg::CLINT_ID]),
    .rsp_ready_i   (dev_rsp_ready[uc_map_pkg::CLINT_ID]),
    .rsp_rdata_o   (dev_rsp_rdata[uc_map_pkg::CLINT_ID]),
    .rsp_src_o     (dev_rsp_src[uc_map_pkg::CLINT_ID]),
    .timer_irq_o   (timer_irq_o),
    .software_irq_o(software_irq_o)
  );

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    uc_mem_bank #(
      .NUM_BANKS (NUM_BANKS),
      .BANK_WORDS(BANK_WORDS)
    ) u_bank (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_v_i    (dev_req_v[uc_map_pkg::BANK_ID0 + b]),
      .req_ready_o(dev_req_ready[uc_map_pkg::BANK_ID0 + b]),
      .req_op_i   (dev_req_op[uc_map_pkg::BANK_ID0 + b]),
      .req_addr_i (dev_req_addr[uc_map_pkg::BANK_ID0 + b]),
      .req_wdata_i(dev_req_wdata[uc_map_pkg::BANK_ID0 + b]),
      .req_src_i  (dev_req_src[uc_map_pkg::BANK_ID0 + b]),
      .rsp_v_o    (dev_rsp_v[uc_map_pkg::BANK_ID0 + b]),
      .rsp_ready_i(dev_rsp_ready[uc_map_pkg::BANK_ID0 + b]),
      .rsp_rdata_o(dev_rsp_rdata[uc_map_pkg::BANK_ID0 + b]),
      .rsp_src_o  (dev_rsp_src[uc_map_pkg::BANK_ID0 + b])
    );
  end

endmodule

// ==== devices/uc_mem_bank.sv ====
// One word-addressed on-chip RAM bank with a single-entry response register
`timescale 1ns/1ns

module uc_mem_bank #(
  parameter int NUM_BANKS = 2,
  parameter int BANK_WORDS = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_v_i,
  output logic                          req_ready_o,
  input  uc_msg_pkg::opcode_e           req_op_i,
  input  logic [uc_msg_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [uc_msg_pkg::DATA_W-1:0] req_wdata_i,
  input  uc_msg_pkg::src_id_t           req_src_i,
  output logic                          rsp_v_o,
  input  logic                          rsp_ready_i,
  output logic [uc_msg_pkg::DATA_W-1:0] rsp_rdata_o,
  output uc_msg_pkg::src_id_t           rsp_src_o
);

  // Word index sits above the bank select and wraps at BANK_WORDS
  localparam int IDX_LSB = uc_map_pkg::BANK_LSB + $clog2(NUM_BANKS);
  localparam int IDX_W = $clog2(BANK_WORDS);

  logic                          accept;
  logic [IDX_W-1:0]              idx;
  logic [uc_msg_pkg::DATA_W-1:0] mem_q [BANK_WORDS];

  assign req_ready_o = !rsp_v_o || rsp_ready_i;
  assign accept = req_v_i && req_ready_o;
  assign idx = req_addr_i[IDX_LSB +: IDX_W];

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (req_op_i == uc_msg_pkg::OP_WRITE)
      begin
        mem_q[idx] <= req_wdata_i;
        rsp_rdata_o <= '0;
      end
      else
        rsp_rdata_o <= mem_q[idx];
      rsp_src_o <= req_src_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rsp_v_o <= 1'b0;
    else if (accept)
      rsp_v_o <= 1'b1;
    else if (rsp_ready_i)
      rsp_v_o <= 1'b0;
  end

endmodule

// ==== devices/uc_clint.sv ====
// Core-local interruptor; free-running timer with compare and a software interrupt bit
`timescale 1ns/1ns

module uc_clint (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_v_i,
  output logic                          req_ready_o,
  input  uc_msg_pkg::opcode_e           req_op_i,
  input  logic [uc_msg_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [uc_msg_pkg::DATA_W-1:0] req_wdata_i,
  input  uc_msg_pkg::src_id_t           req_src_i,
  output logic                          rsp_v_o,
  input  logic                          rsp_ready_i,
  output logic [uc_msg_pkg::DATA_W-1:0] rsp_rdata_o,
  output uc_msg_pkg::src_id_t           rsp_src_o,
  output logic                          timer_irq_o,
  output logic                          software_irq_o
);

  logic                             accept;
  logic                             wr_en;
  logic [uc_map_pkg::REG_OFS_W-1:0] ofs;
  logic [uc_msg_pkg::DATA_W-1:0]    mtime_q;
  logic [uc_msg_pkg::DATA_W-1:0]    mtimecmp_q;
  logic                             msip_q;
  logic [uc_msg_pkg::DATA_W-1:0]    rdata;

  assign req_ready_o = !rsp_v_o || rsp_ready_i;
  assign accept = req_v_i && req_ready_o;
  assign wr_en = accept && req_op_i == uc_msg_pkg::OP_WRITE;
  assign ofs = req_addr_i[uc_map_pkg::REG_OFS_W-1:0];

  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign software_irq_o = msip_q;

  always_comb
  begin
    rdata = '0;
    if (req_op_i == uc_msg_pkg::OP_READ)
    begin
      case (ofs)
        uc_map_pkg::CLINT_MSIP_OFS: rdata = uc_msg_pkg::DATA_W'(msip_q);
        uc_map_pkg::CLINT_MTIMECMP_OFS: rdata = mtimecmp_q;
        uc_map_pkg::CLINT_MTIME_OFS: rdata = mtime_q;
        default: rdata = '0;
      endcase
    end
  end

  // Timer counts the core clock, a write overrides the increment
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q <= '0;
      mtimecmp_q <= '1;
      msip_q <= 1'b0;
    end
    else
    begin
      mtime_q <= mtime_q + 1'b1;
      if (wr_en)
      begin
        case (ofs)
          uc_map_pkg::CLINT_MSIP_OFS: msip_q <= req_wdata_i[0];
          uc_map_pkg::CLINT_MTIMECMP_OFS: mtimecmp_q <= req_wdata_i;
          uc_map_pkg::CLINT_MTIME_OFS: mtime_q <= req_wdata_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rsp_v_o <= 1'b0;
    else if (accept)
      rsp_v_o <= 1'b1;
    else if (rsp_ready_i)
      rsp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rsp_rdata_o <= rdata;
      rsp_src_o <= req_src_i;
    end
  end

endmodule

// ==== devices/uc_cfg_regs.sv ====
// Configuration slice; freeze and scratch registers, unmapped local addresses read zero
`timescale 1ns/1ns

module uc_cfg_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_v_i,
  output logic                          req_ready_o,
  input  uc_msg_pkg::opcode_e           req_op_i,
  input  logic [uc_msg_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [uc_msg_pkg::DATA_W-1:0] req_wdata_i,
  input  uc_msg_pkg::src_id_t           req_src_i,
  output logic                          rsp_v_o,
  input  logic                          rsp_ready_i,
  output logic [uc_msg_pkg::DATA_W-1:0] rsp_rdata_o,
  output uc_msg_pkg::src_id_t           rsp_src_o,
  output logic                          freeze_o
);

  logic                             accept;
  logic                             is_cfg;
  logic [uc_map_pkg::REG_OFS_W-1:0] ofs;
  logic [uc_msg_pkg::DATA_W-1:0]    scratch_q;
  logic [uc_msg_pkg::DATA_W-1:0]    rdata;

  assign req_ready_o = !rsp_v_o || rsp_ready_i;
  assign accept = req_v_i && req_ready_o;
  // Other local device fields end up here too
  assign is_cfg = req_addr_i[uc_map_pkg::DEV_LSB +: $bits(uc_map_pkg::dev_e)]
                  == uc_map_pkg::DEV_CFG;
  assign ofs = req_addr_i[uc_map_pkg::REG_OFS_W-1:0];

  always_comb
  begin
    rdata = '0;
    if (is_cfg && req_op_i == uc_msg_pkg::OP_READ)
    begin
      case (ofs)
        uc_map_pkg::CFG_FREEZE_OFS: rdata = uc_msg_pkg::DATA_W'(freeze_o);
        uc_map_pkg::CFG_SCRATCH_OFS: rdata = scratch_q;
        default: rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      freeze_o <= 1'b1;
      scratch_q <= '0;
    end
    else if (accept && is_cfg && req_op_i == uc_msg_pkg::OP_WRITE)
    begin
      if (ofs == uc_map_pkg::CFG_FREEZE_OFS)
        freeze_o <= req_wdata_i[0];
      else if (ofs == uc_map_pkg::CFG_SCRATCH_OFS)
        scratch_q <= req_wdata_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rsp_v_o <= 1'b0;
    else if (accept)
      rsp_v_o <= 1'b1;
    else if (rsp_ready_i)
      rsp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      rsp_rdata_o <= rdata;
      rsp_src_o <= req_src_i;
    end
  end

endmodule

// ==== xbar/uc_rev_xbar.sv ====
// Reverse crossbar; returns each device response to the port named in its source id
`timescale 1ns/1ns

module uc_rev_xbar #(
  parameter int NUM_BANKS = 2,
  localparam int NUM_DEV = uc_map_pkg::BANK_ID0 + NUM_BANKS
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic [NUM_DEV-1:0]                                       dev_rsp_v_i,
  output logic [NUM_DEV-1:0]                                       dev_rsp_ready_o,
  input  logic [NUM_DEV-1:0][uc_msg_pkg::DATA_W-1:0]               dev_rsp_rdata_i,
  input  uc_msg_pkg::src_id_t [NUM_DEV-1:0]                        dev_rsp_src_i,
  output logic [uc_msg_pkg::NUM_SRC-1:0]                           rsp_v_o,
  input  logic [uc_msg_pkg::NUM_SRC-1:0]                           rsp_ready_i,
  output logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::DATA_W-1:0]   rsp_rdata_o,
  output logic [uc_msg_pkg::NUM_SRC-1:0]                           rsp_done_o
);

  logic [uc_msg_pkg::NUM_SRC-1:0][NUM_DEV-1:0] arb_req;
  logic [uc_msg_pkg::NUM_SRC-1:0][NUM_DEV-1:0] arb_gnt;

  for (genvar p = 0; p < uc_msg_pkg::NUM_SRC; p++)
  begin : g_port
    for (genvar d = 0; d < NUM_DEV; d++)
    begin : g_dev
      assign arb_req[p][d] = dev_rsp_v_i[d] && (dev_rsp_src_i[d] == uc_msg_pkg::src_id_t'(p));
    end

    // Normally a single device answers a port
    uc_rr_arb #(.N(NUM_DEV)) u_arb (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (arb_req[p]),
      .advance_i(rsp_done_o[p]),
      .grant_o  (arb_gnt[p])
    );

    assign rsp_v_o[p] = |arb_gnt[p];
    assign rsp_done_o[p] = rsp_v_o[p] && rsp_ready_i[p];
  end

  always_comb
  begin
    dev_rsp_ready_o = '0;
    for (int p = 0; p < uc_msg_pkg::NUM_SRC; p++)
    begin
      rsp_rdata_o[p] = '0;
      for (int d = 0; d < NUM_DEV; d++)
      begin
        if (arb_gnt[p][d])
        begin
          rsp_rdata_o[p] = dev_rsp_rdata_i[d];
          dev_rsp_ready_o[d] = rsp_ready_i[p];
        end
      end
    end
  end

endmodule

// ==== xbar/uc_fwd_xbar.sv ====
// Forward crossbar; decodes request addresses and grants each device to one port at a time
`timescale 1ns/1ns

module uc_fwd_xbar #(
  parameter int NUM_BANKS = 2,
  localparam int NUM_DEV = uc_map_pkg::BANK_ID0 + NUM_BANKS
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic [uc_msg_pkg::NUM_SRC-1:0]                           req_v_i,
  output logic [uc_msg_pkg::NUM_SRC-1:0]                           req_ready_o,
  input  uc_msg_pkg::opcode_e [uc_msg_pkg::NUM_SRC-1:0]            req_op_i,
  input  logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [uc_msg_pkg::NUM_SRC-1:0][uc_msg_pkg::DATA_W-1:0]   req_wdata_i,
  output logic [NUM_DEV-1:0]                                       dev_req_v_o,
  input  logic [NUM_DEV-1:0]                                       dev_req_ready_i,
  output uc_msg_pkg::opcode_e [NUM_DEV-1:0]                        dev_req_op_o,
  output logic [NUM_DEV-1:0][uc_msg_pkg::ADDR_W-1:0]               dev_req_addr_o,
  output logic [NUM_DEV-1:0][uc_msg_pkg::DATA_W-1:0]               dev_req_wdata_o,
  output uc_msg_pkg::src_id_t [NUM_DEV-1:0]                        dev_req_src_o,
  input  logic [uc_msg_pkg::NUM_SRC-1:0]                           rsp_done_i
);

  localparam int DEV_W = $clog2(NUM_DEV);
  localparam int SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [uc_msg_pkg::NUM_SRC-1:0][DEV_W-1:0]   dst;
  logic [uc_msg_pkg::NUM_SRC-1:0]              busy_q;
  logic [NUM_DEV-1:0][uc_msg_pkg::NUM_SRC-1:0] arb_req;
  logic [NUM_DEV-1:0][uc_msg_pkg::NUM_SRC-1:0] arb_gnt;

  // Address decode per port
  always_comb
  begin
    for (int p = 0; p < uc_msg_pkg::NUM_SRC; p++)
    begin
      if (req_addr_i[p] >= uc_map_pkg::MEM_BASE)
        dst[p] = DEV_W'(uc_map_pkg::BANK_ID0
                        + int'(req_addr_i[p][uc_map_pkg::BANK_LSB +: SEL_W]) % NUM_BANKS);
      else if (req_addr_i[p][uc_map_pkg::DEV_LSB +: $bits(uc_map_pkg::dev_e)]
               == uc_map_pkg::DEV_CLINT)
        dst[p] = DEV_W'(uc_map_pkg::CLINT_ID);
      else
        dst[p] = DEV_W'(uc_map_pkg::CFG_ID);
    end
  end

  for (genvar d = 0; d < NUM_DEV; d++)
  begin : g_dev
    for (genvar p = 0; p < uc_msg_pkg::NUM_SRC; p++)
    begin : g_src
      // No grants while in reset
      assign arb_req[d][p] = rst_n_i && req_v_i[p] && !busy_q[p] && (dst[p] == DEV_W'(d));
    end

    uc_rr_arb #(.N(uc_msg_pkg::NUM_SRC)) u_arb (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (arb_req[d]),
      .advance_i(dev_req_v_o[d] && dev_req_ready_i[d]),
      .grant_o  (arb_gnt[d])
    );
  end

  // Route the granted port to each device
  always_comb
  begin
    req_ready_o = '0;
    for (int d = 0; d < NUM_DEV; d++)
    begin
      dev_req_v_o[d] = |arb_gnt[d];
      dev_req_op_o[d] = uc_msg_pkg::OP_READ;
      dev_req_addr_o[d] = '0;
      dev_req_wdata_o[d] = '0;
      dev_req_src_o[d] = '0;
      for (int p = 0; p < uc_msg_pkg::NUM_SRC; p++)
      begin
        if (arb_gnt[d][p])
        begin
          dev_req_op_o[d] = req_op_i[p];
          dev_req_addr_o[d] = req_addr_i[p];
          dev_req_wdata_o[d] = req_wdata_i[p];
          dev_req_src_o[d] = uc_msg_pkg::src_id_t'(p);
          req_ready_o[p] = dev_req_ready_i[d];
        end
      end
    end
  end

  // One outstanding request per port
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      busy_q <= '0;
    else
      busy_q <= (busy_q & ~rsp_done_i) | (req_v_i & req_ready_o);
  end

endmodule

// ==== xbar/uc_rr_arb.sv ====
// Round-robin arbiter with a one-hot grant, used per device and per port by the crossbars
`timescale 1ns/1ns

module uc_rr_arb #(
  parameter int N = 2
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic [N-1:0] req_i,
  input  logic         advance_i,
  output logic [N-1:0] grant_o
);

  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] win;

  // Scan downward so the request closest to the pointer wins
  always_comb
  begin
    win = ptr_q;
    for (int i = N - 1; i >= 0; i--)
    begin
      if (req_i[(int'(ptr_q) + i) % N])
        win = PTR_W'((int'(ptr_q) + i) % N);
    end
    grant_o = '0;
    grant_o[win] = |req_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      ptr_q <= '0;
    else if (advance_i && |req_i)
      ptr_q <= (int'(win) == N - 1) ? '0 : win + 1'b1;
  end

endmodule

// ==== common/uc_map_pkg.sv ====
// Address map, device slots and register offsets used by the crossbars and devices
package uc_map_pkg;

  // At or above this address is memory, below it local devices
  localparam logic [uc_msg_pkg::ADDR_W-1:0] MEM_BASE = 'h80000;

  // Local device field sits right above the register offset
  localparam int REG_OFS_W = 12;
  localparam int DEV_LSB = REG_OFS_W;

  typedef enum logic [3:0] {
    DEV_CFG   = 4'd0,
    DEV_CLINT = 4'd1
  } dev_e;

  // Device slots on the crossbars, banks follow the clint
  localparam int CFG_ID = 0;
  localparam int CLINT_ID = 1;
  localparam int BANK_ID0 = 2;

  localparam logic [REG_OFS_W-1:0] CFG_FREEZE_OFS = 12'h000;
  localparam logic [REG_OFS_W-1:0] CFG_SCRATCH_OFS = 12'h004;

  localparam logic [REG_OFS_W-1:0] CLINT_MSIP_OFS = 12'h000;
  localparam logic [REG_OFS_W-1:0] CLINT_MTIMECMP_OFS = 12'h008;
  localparam logic [REG_OFS_W-1:0] CLINT_MTIME_OFS = 12'h010;

  // Words are 4 bytes
  localparam int BANK_LSB = 2;

endpackage

// ==== common/uc_msg_pkg.sv ====
// Message widths, opcodes and port ids shared by every block of the interconnect
package uc_msg_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 20;

  // Port 0 is the core, port 1 the host I/O
  localparam int NUM_SRC = 2;

  typedef logic [$clog2(NUM_SRC)-1:0] src_id_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } opcode_e;

endpackage
